/* design/bru_params.svh */
`ifndef BRU_PARAMS_SVH
`define BRU_PARAMS_SVH

// datapath widths
`define BRU_XLEN       32
`define BRU_VADDR_W    32

// physical register file
`define BRU_RNID_W     6
`define BRU_PREG_NUM   64

// result forwarding
`define BRU_FWD_NUM    2

// branch tracking and commit
`define BRU_BRTAG_NUM  4
`define BRU_CMT_ID_W   6

`endif

/* design/bru_pkg.sv */
`default_nettype none

package bru_pkg;
  `include "bru_params.svh"

  typedef enum logic [2:0] {
    OP_EQ,
    OP_NE,
    OP_LT,
    OP_GE,
    OP_LTU,
    OP_GEU,
    OP_JUMP,
    OP_NONE
  } bru_op_e;

  typedef enum logic [1:0] {
    IMM_SB,
    IMM_UJ,
    IMM_I,
    IMM_NONE
  } bru_imm_e;

  typedef struct packed {
    bru_op_e  op;
    bru_imm_e imm;
    logic     wr_rd;  // jal/jalr link
  } pipe_ctrl_t;

  typedef struct packed {
    logic                                 valid;
    logic [31:0]                          inst;
    logic [`BRU_VADDR_W-1:0]              pc_addr;
    logic                                 is_rvc;
    logic [`BRU_CMT_ID_W-1:0]             cmt_id;
    logic [$clog2(`BRU_BRTAG_NUM)-1:0]    brtag;
    logic [`BRU_BRTAG_NUM-1:0]            br_mask;
    logic                                 rs1_valid;
    logic [`BRU_RNID_W-1:0]               rs1_rnid;
    logic                                 rs1_pred_ready;
    logic                                 rs2_valid;
    logic [`BRU_RNID_W-1:0]               rs2_rnid;
    logic                                 rs2_pred_ready;
    logic                                 rd_valid;
    logic [`BRU_RNID_W-1:0]               rd_rnid;
    logic [4:0]                           rd_regidx;  // architectural rd
  } issue_t;

  typedef struct packed {
    logic                   valid;
    logic [`BRU_RNID_W-1:0] rd_rnid;
    logic [`BRU_XLEN-1:0]   rd_data;
  } phy_wr_t;

  typedef struct packed {
    logic                              update;
    logic                              dead;
    logic                              mispredict;
    logic [`BRU_VADDR_W-1:0]           pc_vaddr;
    logic [`BRU_VADDR_W-1:0]           target_vaddr;
    logic [`BRU_CMT_ID_W-1:0]          cmt_id;
    logic [$clog2(`BRU_BRTAG_NUM)-1:0] brtag;
    logic [`BRU_BRTAG_NUM-1:0]         br_mask;
  } br_upd_t;

  typedef struct packed {
    logic                     done;
    logic [`BRU_CMT_ID_W-1:0] cmt_id;
  } done_t;

  // younger op depends on a live mispredicted branch
  function automatic logic is_br_kill(input logic [`BRU_BRTAG_NUM-1:0] br_mask,
                                      input br_upd_t upd);
    return upd.update & ~upd.dead & upd.mispredict & br_mask[upd.brtag];
  endfunction

  function automatic logic [`BRU_VADDR_W-1:0] sext_sb(input logic [31:0] inst);
    return {{(`BRU_VADDR_W-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  endfunction

  function automatic logic [`BRU_VADDR_W-1:0] sext_uj(input logic [31:0] inst);
    return {{(`BRU_VADDR_W-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
  endfunction

  function automatic logic [`BRU_VADDR_W-1:0] sext_i(input logic [31:0] inst);
    return {{(`BRU_VADDR_W-12){inst[31]}}, inst[31:20]};
  endfunction

endpackage

`default_nettype wire

/* design/bru_decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "bru_params.svh"

module bru_decode_stage
  import bru_pkg::*;
(
  input  wire logic    i_clk,
  input  wire logic    i_reset_n,
  input  wire issue_t  i_issue,
  input  wire br_upd_t i_br_upd,
  input  wire logic    i_commit_flush,
  output issue_t       o_ex1_issue,
  output pipe_ctrl_t   o_ex1_ctrl,
  output logic         o_ex1_dead
);

  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  pipe_ctrl_t w_ex0_ctrl;
  logic       w_ex0_kill;
  logic       r_ex1_valid;
  logic       r_ex1_dead;
  issue_t     r_ex1_issue;
  pipe_ctrl_t r_ex1_ctrl;

  always_comb begin
    w_ex0_ctrl = '{op: OP_NONE, imm: IMM_NONE, wr_rd: 1'b0};
    case (i_issue.inst[6:0])
      OPC_BRANCH: begin
        w_ex0_ctrl.imm = IMM_SB;
        case (i_issue.inst[14:12])
          3'b000:  w_ex0_ctrl.op = OP_EQ;
          3'b001:  w_ex0_ctrl.op = OP_NE;
          3'b100:  w_ex0_ctrl.op = OP_LT;
          3'b101:  w_ex0_ctrl.op = OP_GE;
          3'b110:  w_ex0_ctrl.op = OP_LTU;
          3'b111:  w_ex0_ctrl.op = OP_GEU;
          default: w_ex0_ctrl.op = OP_NONE;  // reserved funct3
        endcase
      end
      OPC_JAL: begin
        w_ex0_ctrl = '{op: OP_JUMP, imm: IMM_UJ, wr_rd: 1'b1};
      end
      OPC_JALR: begin
        w_ex0_ctrl = '{op: OP_JUMP, imm: IMM_I, wr_rd: 1'b1};
      end
      default: begin
        w_ex0_ctrl.op = OP_NONE;
      end
    endcase
  end

  assign w_ex0_kill = is_br_kill(i_issue.br_mask, i_br_upd);

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_valid <= 1'b0;
      r_ex1_dead  <= 1'b0;
    end else begin
      r_ex1_valid <= i_issue.valid;
      r_ex1_dead  <= i_issue.valid & (w_ex0_kill | i_commit_flush);
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex1_issue <= i_issue;
    r_ex1_ctrl  <= w_ex0_ctrl;
  end

  always_comb begin
    o_ex1_issue       = r_ex1_issue;
    o_ex1_issue.valid = r_ex1_valid;
  end

  assign o_ex1_ctrl = r_ex1_ctrl;
  assign o_ex1_dead = r_ex1_dead;

endmodule

`default_nettype wire

/* design/bru_regfile.sv */
`timescale 1ns/1ps
`default_nettype none
`include "bru_params.svh"

module bru_regfile
  import bru_pkg::*;
(
  input  wire logic                   i_clk,
  input  wire logic                   i_reset_n,
  input  wire phy_wr_t                i_fwd_bus [`BRU_FWD_NUM],
  input  wire phy_wr_t                i_link_wr,
  input  wire logic [`BRU_RNID_W-1:0] i_rs1_rnid,
  input  wire logic [`BRU_RNID_W-1:0] i_rs2_rnid,
  output logic [`BRU_XLEN-1:0]        o_rs1_data,
  output logic [`BRU_XLEN-1:0]        o_rs2_data
);

  logic [`BRU_XLEN-1:0]   r_regs    [`BRU_PREG_NUM];
  logic [`BRU_RNID_W-1:0] w_rd_rnid [2];
  logic [`BRU_XLEN-1:0]   w_rd_data [2];

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < `BRU_PREG_NUM; i++) begin
        r_regs[i] <= '0;
      end
    end else begin
      for (int p = 0; p < `BRU_FWD_NUM; p++) begin
        if (i_fwd_bus[p].valid && (i_fwd_bus[p].rd_rnid != '0)) begin
          r_regs[i_fwd_bus[p].rd_rnid] <= i_fwd_bus[p].rd_data;
        end
      end
      if (i_link_wr.valid && (i_link_wr.rd_rnid != '0)) begin
        r_regs[i_link_wr.rd_rnid] <= i_link_wr.rd_data;
      end
    end
  end

  assign w_rd_rnid[0] = i_rs1_rnid;
  assign w_rd_rnid[1] = i_rs2_rnid;

  for (genvar r = 0; r < 2; r++) begin : g_rd_port
    always_comb begin
      w_rd_data[r] = r_regs[w_rd_rnid[r]];
      for (int p = 0; p < `BRU_FWD_NUM; p++) begin
        if (i_fwd_bus[p].valid && (i_fwd_bus[p].rd_rnid == w_rd_rnid[r])) begin
          w_rd_data[r] = i_fwd_bus[p].rd_data;  // write-through
        end
      end
      if (i_link_wr.valid && (i_link_wr.rd_rnid == w_rd_rnid[r])) begin
        w_rd_data[r] = i_link_wr.rd_data;
      end
      if (w_rd_rnid[r] == '0) begin
        w_rd_data[r] = '0;
      end
    end
  end

  assign o_rs1_data = w_rd_data[0];
  assign o_rs2_data = w_rd_data[1];

endmodule

`default_nettype wire

/* design/bru_operand_stage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "bru_params.svh"

module bru_operand_stage
  import bru_pkg::*;
(
  input  wire logic                 i_clk,
  input  wire logic                 i_reset_n,
  input  wire issue_t               i_ex1_issue,
  input  wire pipe_ctrl_t           i_ex1_ctrl,
  input  wire logic                 i_ex1_dead,
  input  wire logic [`BRU_XLEN-1:0] i_rs1_data,
  input  wire logic [`BRU_XLEN-1:0] i_rs2_data,
  input  wire phy_wr_t              i_fwd_bus [`BRU_FWD_NUM],
  input  wire br_upd_t              i_br_upd,
  input  wire logic                 i_commit_flush,
  output logic [`BRU_RNID_W-1:0]    o_rs1_rnid,
  output logic [`BRU_RNID_W-1:0]    o_rs2_rnid,
  output issue_t                    o_ex2_issue,
  output pipe_ctrl_t                o_ex2_ctrl,
  output logic                      o_ex2_dead,
  output logic [`BRU_XLEN-1:0]      o_ex2_rs1,
  output logic [`BRU_XLEN-1:0]      o_ex2_rs2,
  output logic                      o_ex2_pred_hit
);

  logic                    w_ex1_kill;
  logic                    r_ex2_valid;
  logic                    r_ex2_dead;
  issue_t                  r_ex2_issue;
  pipe_ctrl_t              r_ex2_ctrl;
  logic [`BRU_XLEN-1:0]    r_ex2_rs1_data;
  logic [`BRU_XLEN-1:0]    r_ex2_rs2_data;
  logic [`BRU_FWD_NUM-1:0] w_rs1_fwd_hit;
  logic [`BRU_FWD_NUM-1:0] w_rs2_fwd_hit;
  logic [`BRU_XLEN-1:0]    w_rs1_fwd_data;
  logic [`BRU_XLEN-1:0]    w_rs2_fwd_data;
  logic                    w_rs1_pred_hit;
  logic                    w_rs2_pred_hit;

  assign o_rs1_rnid = i_ex1_issue.rs1_rnid;
  assign o_rs2_rnid = i_ex1_issue.rs2_rnid;

  assign w_ex1_kill = is_br_kill(i_ex1_issue.br_mask, i_br_upd);

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex2_valid <= 1'b0;
      r_ex2_dead  <= 1'b0;
    end else begin
      r_ex2_valid <= i_ex1_issue.valid;
      r_ex2_dead  <= i_ex1_issue.valid & (i_ex1_dead | w_ex1_kill | i_commit_flush);
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex2_issue    <= i_ex1_issue;
    r_ex2_ctrl     <= i_ex1_ctrl;
    r_ex2_rs1_data <= i_rs1_data;
    r_ex2_rs2_data <= i_rs2_data;
  end

  // one-hot match on the bus with x0 never forwarded
  always_comb begin
    w_rs1_fwd_data = '0;
    w_rs2_fwd_data = '0;
    for (int p = 0; p < `BRU_FWD_NUM; p++) begin
      w_rs1_fwd_hit[p] = r_ex2_issue.rs1_valid & i_fwd_bus[p].valid &
                         (i_fwd_bus[p].rd_rnid == r_ex2_issue.rs1_rnid) &
                         (r_ex2_issue.rs1_rnid != '0);
      w_rs2_fwd_hit[p] = r_ex2_issue.rs2_valid & i_fwd_bus[p].valid &
                         (i_fwd_bus[p].rd_rnid == r_ex2_issue.rs2_rnid) &
                         (r_ex2_issue.rs2_rnid != '0);
      w_rs1_fwd_data = w_rs1_fwd_data | ({`BRU_XLEN{w_rs1_fwd_hit[p]}} & i_fwd_bus[p].rd_data);
      w_rs2_fwd_data = w_rs2_fwd_data | ({`BRU_XLEN{w_rs2_fwd_hit[p]}} & i_fwd_bus[p].rd_data);
    end
  end

  // speculative operand must show up this cycle
  assign w_rs1_pred_hit = (r_ex2_issue.rs1_valid & r_ex2_issue.rs1_pred_ready) ?
                          |w_rs1_fwd_hit : 1'b1;
  assign w_rs2_pred_hit = (r_ex2_issue.rs2_valid & r_ex2_issue.rs2_pred_ready) ?
                          |w_rs2_fwd_hit : 1'b1;

  always_comb begin
    o_ex2_issue       = r_ex2_issue;
    o_ex2_issue.valid = r_ex2_valid;
  end

  assign o_ex2_ctrl     = r_ex2_ctrl;
  assign o_ex2_dead     = r_ex2_dead;
  assign o_ex2_rs1      = |w_rs1_fwd_hit ? w_rs1_fwd_data : r_ex2_rs1_data;
  assign o_ex2_rs2      = |w_rs2_fwd_hit ? w_rs2_fwd_data : r_ex2_rs2_data;
  assign o_ex2_pred_hit = w_rs1_pred_hit & w_rs2_pred_hit;

endmodule

`default_nettype wire

/* design/bru_exec_stage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "bru_params.svh"

module bru_exec_stage
  import bru_pkg::*;
(
  input  wire logic                 i_clk,
  input  wire logic                 i_reset_n,
  input  wire issue_t               i_ex2_issue,
  input  wire pipe_ctrl_t           i_ex2_ctrl,
  input  wire logic                 i_ex2_dead,
  input  wire logic [`BRU_XLEN-1:0] i_ex2_rs1,
  input  wire logic [`BRU_XLEN-1:0] i_ex2_rs2,
  input  wire logic                 i_ex2_pred_hit,
  input  wire br_upd_t              i_br_upd_fb,
  input  wire logic                 i_commit_flush,
  output br_upd_t                   o_br_upd,
  output done_t                     o_done,
  output phy_wr_t                   o_phy_wr
);

  logic                    w_ex2_taken;
  logic [`BRU_VADDR_W-1:0] w_ex2_target;
  logic [`BRU_VADDR_W-1:0] w_ex2_jalr_sum;
  logic                    w_ex2_kill;
  logic                    r_ex3_valid;
  logic                    r_ex3_dead;
  issue_t                  r_ex3_issue;
  pipe_ctrl_t              r_ex3_ctrl;
  logic                    r_ex3_taken;
  logic [`BRU_VADDR_W-1:0] r_ex3_target;
  logic                    r_ex3_pred_hit;
  logic [`BRU_VADDR_W-1:0] w_ex3_link_addr;
  logic                    w_ex3_live;

  always_comb begin
    case (i_ex2_ctrl.op)
      OP_EQ:   w_ex2_taken = i_ex2_rs1 == i_ex2_rs2;
      OP_NE:   w_ex2_taken = i_ex2_rs1 != i_ex2_rs2;
      OP_LT:   w_ex2_taken = $signed(i_ex2_rs1) < $signed(i_ex2_rs2);
      OP_GE:   w_ex2_taken = $signed(i_ex2_rs1) >= $signed(i_ex2_rs2);
      OP_LTU:  w_ex2_taken = i_ex2_rs1 < i_ex2_rs2;
      OP_GEU:  w_ex2_taken = i_ex2_rs1 >= i_ex2_rs2;
      OP_JUMP: w_ex2_taken = 1'b1;  // jal/jalr
      default: w_ex2_taken = 1'b0;
    endcase
  end

  assign w_ex2_jalr_sum = i_ex2_rs1[`BRU_VADDR_W-1:0] + sext_i(i_ex2_issue.inst);

  always_comb begin
    case (i_ex2_ctrl.imm)
      IMM_SB:  w_ex2_target = i_ex2_issue.pc_addr + sext_sb(i_ex2_issue.inst);
      IMM_UJ:  w_ex2_target = i_ex2_issue.pc_addr + sext_uj(i_ex2_issue.inst);
      IMM_I:   w_ex2_target = {w_ex2_jalr_sum[`BRU_VADDR_W-1:1], 1'b0};  // lsb cleared
      default: w_ex2_target = i_ex2_issue.pc_addr;
    endcase
  end

  assign w_ex2_kill = is_br_kill(i_ex2_issue.br_mask, i_br_upd_fb);

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex3_valid <= 1'b0;
      r_ex3_dead  <= 1'b0;
    end else begin
      r_ex3_valid <= i_ex2_issue.valid;
      r_ex3_dead  <= i_ex2_issue.valid & (i_ex2_dead | w_ex2_kill | i_commit_flush);
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex3_issue    <= i_ex2_issue;
    r_ex3_ctrl     <= i_ex2_ctrl;
    r_ex3_taken    <= w_ex2_taken;
    r_ex3_target   <= w_ex2_target;
    r_ex3_pred_hit <= i_ex2_pred_hit;
  end

  assign w_ex3_link_addr = r_ex3_issue.pc_addr +
                           (r_ex3_issue.is_rvc ? `BRU_VADDR_W'(2) : `BRU_VADDR_W'(4));
  assign w_ex3_live = r_ex3_valid & r_ex3_pred_hit & ~r_ex3_dead;

  always_comb begin
    o_br_upd.update       = r_ex3_valid & r_ex3_pred_hit;
    o_br_upd.dead         = r_ex3_dead;
    o_br_upd.mispredict   = r_ex3_taken;  // every taken op redirects
    o_br_upd.pc_vaddr     = r_ex3_issue.pc_addr;
    o_br_upd.target_vaddr = r_ex3_target;
    o_br_upd.cmt_id       = r_ex3_issue.cmt_id;
    o_br_upd.brtag        = r_ex3_issue.brtag;
    o_br_upd.br_mask      = r_ex3_issue.br_mask;
  end

  always_comb begin
    o_done.done   = w_ex3_live;
    o_done.cmt_id = r_ex3_issue.cmt_id;
  end

  always_comb begin
    o_phy_wr.valid   = w_ex3_live & r_ex3_ctrl.wr_rd & (r_ex3_issue.rd_regidx != 5'd0);
    o_phy_wr.rd_rnid = r_ex3_issue.rd_rnid;
    o_phy_wr.rd_data = `BRU_XLEN'(w_ex3_link_addr);
  end

endmodule

`default_nettype wire

/* design/bru_pipe_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "bru_params.svh"

module bru_pipe_top
  import bru_pkg::*;
(
  input  wire logic    i_clk,
  input  wire logic    i_reset_n,
  input  wire issue_t  i_issue,
  input  wire phy_wr_t i_fwd_bus [`BRU_FWD_NUM],
  input  wire logic    i_commit_flush,
  output br_upd_t      o_br_upd,
  output done_t        o_done,
  output phy_wr_t      o_phy_wr
);

  issue_t                 ex1_issue;
  pipe_ctrl_t             ex1_ctrl;
  logic                   ex1_dead;
  logic [`BRU_RNID_W-1:0] rs1_rnid;
  logic [`BRU_RNID_W-1:0] rs2_rnid;
  logic [`BRU_XLEN-1:0]   rs1_data;
  logic [`BRU_XLEN-1:0]   rs2_data;
  issue_t                 ex2_issue;
  pipe_ctrl_t             ex2_ctrl;
  logic                   ex2_dead;
  logic [`BRU_XLEN-1:0]   ex2_rs1;
  logic [`BRU_XLEN-1:0]   ex2_rs2;
  logic                   ex2_pred_hit;

  bru_decode_stage u_decode (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_issue        (i_issue),
    .i_br_upd       (o_br_upd),
    .i_commit_flush (i_commit_flush),
    .o_ex1_issue    (ex1_issue),
    .o_ex1_ctrl     (ex1_ctrl),
    .o_ex1_dead     (ex1_dead)
  );

  bru_regfile u_regfile (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_fwd_bus  (i_fwd_bus),
    .i_link_wr  (o_phy_wr),  // link result back into the file
    .i_rs1_rnid (rs1_rnid),
    .i_rs2_rnid (rs2_rnid),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  bru_operand_stage u_operand (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_ex1_issue    (ex1_issue),
    .i_ex1_ctrl     (ex1_ctrl),
    .i_ex1_dead     (ex1_dead),
    .i_rs1_data     (rs1_data),
    .i_rs2_data     (rs2_data),
    .i_fwd_bus      (i_fwd_bus),
    .i_br_upd       (o_br_upd),
    .i_commit_flush (i_commit_flush),
    .o_rs1_rnid     (rs1_rnid),
    .o_rs2_rnid     (rs2_rnid),
    .o_ex2_issue    (ex2_issue),
    .o_ex2_ctrl     (ex2_ctrl),
    .o_ex2_dead     (ex2_dead),
    .o_ex2_rs1      (ex2_rs1),
    .o_ex2_rs2      (ex2_rs2),
    .o_ex2_pred_hit (ex2_pred_hit)
  );

  bru_exec_stage u_exec (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_ex2_issue    (ex2_issue),
    .i_ex2_ctrl     (ex2_ctrl),
    .i_ex2_dead     (ex2_dead),
    .i_ex2_rs1      (ex2_rs1),
    .i_ex2_rs2      (ex2_rs2),
    .i_ex2_pred_hit (ex2_pred_hit),
    .i_br_upd_fb    (o_br_upd),
    .i_commit_flush (i_commit_flush),
    .o_br_upd       (o_br_upd),
    .o_done         (o_done),
    .o_phy_wr       (o_phy_wr)
  );

endmodule

`default_nettype wire

/* dv/bru_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "bru_params.svh"

module bru_tb
  import bru_pkg::*;
();

  localparam int MAX_OPS = 24;
  // branch kinds use their funct3 and jumps take the two unused codes
  localparam logic [2:0] K_BEQ  = 3'd0;
  localparam logic [2:0] K_BNE  = 3'd1;
  localparam logic [2:0] K_JAL  = 3'd2;
  localparam logic [2:0] K_JALR = 3'd3;
  localparam logic [2:0] K_BLT  = 3'd4;
  localparam logic [2:0] K_BGE  = 3'd5;
  localparam logic [2:0] K_BLTU = 3'd6;
  localparam logic [2:0] K_BGEU = 3'd7;

  typedef struct packed {
    logic [2:0]  kind;
    logic [31:0] imm;
    logic [31:0] pc;
    logic        rvc;
    logic [5:0]  rs1;
    logic [5:0]  rs2;
    logic        pr1;
    logic        pr2;
    logic [5:0]  rd_rnid;
    logic [4:0]  rd_idx;
    logic [1:0]  brtag;
    logic [3:0]  mask;
    logic [1:0]  fwd_cyc;   // 0 for none or the bus cycle after issue
    logic [5:0]  fwd_rnid;
    logic [31:0] fwd_data;
    logic        chain;     // next op issues one cycle later
    logic        flush;
    logic        exp_dead;
  } op_row_t;

  typedef struct packed {
    logic        upd;
    logic        dead;
    logic        taken;
    logic [31:0] target;
    logic        wr;
    logic [31:0] link;
  } op_exp_t;

  logic    i_clk;
  logic    i_reset_n;
  issue_t  i_issue;
  phy_wr_t i_fwd_bus [`BRU_FWD_NUM];
  logic    i_commit_flush;
  br_upd_t o_br_upd;
  done_t   o_done;
  phy_wr_t o_phy_wr;

  op_row_t     ops       [MAX_OPS];
  string       names     [MAX_OPS];
  op_exp_t     exps      [MAX_OPS];
  int          issue_cyc [MAX_OPS];
  logic [31:0] model_regs [`BRU_PREG_NUM];
  logic [15:0] lfsr;
  int          cyc = 0;
  int          n_ops;
  int          err_cnt;
  int          fail_cnt;

  bru_pipe_top uut (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_issue        (i_issue),
    .i_fwd_bus      (i_fwd_bus),
    .i_commit_flush (i_commit_flush),
    .o_br_upd       (o_br_upd),
    .o_done         (o_done),
    .o_phy_wr       (o_phy_wr)
  );

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cyc <= cyc + 1;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    w = '0;
    for (int b = 0; b < 32; b++) begin
      w = {w[30:0], lfsr[15]};
      lfsr = lfsr_step(lfsr);
    end
    return w;
  endfunction

  function automatic logic [31:0] edge_val(input int r);
    case (r)
      1, 2:    return 32'h0000_0005;
      3:       return 32'hffff_fff0;  // -16
      4:       return 32'h0000_0010;
      5:       return 32'h8000_0000;
      6:       return 32'h7fff_ffff;
      7:       return 32'h0000_1000;  // jalr base
      default: return 32'h0000_0104;  // link of jal_link
    endcase
  endfunction

  function automatic logic [31:0] encode(input logic [2:0] kind, input logic [4:0] rd,
                                         input logic [31:0] imm);
    logic [31:0] inst;
    if (kind == K_JAL) begin
      inst = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    end else if (kind == K_JALR) begin
      inst = {imm[11:0], 5'd0, 3'b000, rd, 7'b1100111};
    end else begin
      inst = {imm[12], imm[10:5], 5'd0, 5'd0, kind, imm[4:1], imm[11], 7'b1100011};
    end
    return inst;
  endfunction

  // expected results from the RISC-V branch and jump rules
  function automatic op_exp_t predict(input op_row_t op);
    op_exp_t     e;
    logic [31:0] a;
    logic [31:0] b;
    logic        miss1;
    logic        miss2;
    logic        jump;
    a = model_regs[op.rs1];
    b = model_regs[op.rs2];
    jump = (op.kind == K_JAL) || (op.kind == K_JALR);
    case (op.kind)
      K_BEQ:   e.taken = (a == b);
      K_BNE:   e.taken = (a != b);
      K_BLT:   e.taken = ($signed(a) < $signed(b));
      K_BGE:   e.taken = ($signed(a) >= $signed(b));
      K_BLTU:  e.taken = (a < b);
      K_BGEU:  e.taken = (a >= b);
      default: e.taken = 1'b1;
    endcase
    e.target = (op.kind == K_JALR) ? ((a + op.imm) & ~32'd1) : (op.pc + op.imm);
    e.link = op.pc + (op.rvc ? 32'd2 : 32'd4);
    miss1 = op.pr1 && !(op.fwd_cyc == 2'd2 && op.fwd_rnid == op.rs1);
    miss2 = op.pr2 && !(op.fwd_cyc == 2'd2 && op.fwd_rnid == op.rs2);
    e.upd = !(miss1 || miss2);
    e.dead = op.exp_dead;
    e.wr = e.upd && !op.exp_dead && jump && (op.rd_idx != 5'd0);
    return e;
  endfunction

  task automatic add_op(input string name, input logic [2:0] kind, input int imm,
                        input logic [31:0] pc, input logic [5:0] rs1, input logic [5:0] rs2,
                        input logic [5:0] rd_rnid, input logic [4:0] rd_idx);
    ops[n_ops] = '0;
    ops[n_ops].kind = kind;
    ops[n_ops].imm = imm;
    ops[n_ops].pc = pc;
    ops[n_ops].rs1 = rs1;
    ops[n_ops].rs2 = rs2;
    ops[n_ops].rd_rnid = rd_rnid;
    ops[n_ops].rd_idx = rd_idx;
    names[n_ops] = name;
    n_ops++;
  endtask

  task automatic set_spec(input logic pr1, input logic pr2, input logic [1:0] fwd_cyc,
                          input logic [5:0] fwd_rnid, input logic [31:0] fwd_data);
    ops[n_ops-1].pr1 = pr1;
    ops[n_ops-1].pr2 = pr2;
    ops[n_ops-1].fwd_cyc = fwd_cyc;
    ops[n_ops-1].fwd_rnid = fwd_rnid;
    ops[n_ops-1].fwd_data = fwd_data;
  endtask

  task automatic set_group(input logic [1:0] brtag, input logic [3:0] mask, input logic chain,
                           input logic flush, input logic exp_dead);
    ops[n_ops-1].brtag = brtag;
    ops[n_ops-1].mask = mask;
    ops[n_ops-1].chain = chain;
    ops[n_ops-1].flush = flush;
    ops[n_ops-1].exp_dead = exp_dead;
  endtask

  task automatic build_table();
    add_op("beq_equal",    K_BEQ,    64,   32'h0200, 6'd1,  6'd2, 6'd0,  5'd0);
    add_op("bne_equal",    K_BNE,    64,   32'h0204, 6'd1,  6'd2, 6'd0,  5'd0);
    add_op("blt_neg_pos",  K_BLT,   -32,   32'h0240, 6'd3,  6'd4, 6'd0,  5'd0);
    add_op("bge_neg_pos",  K_BGE,   -32,   32'h0244, 6'd3,  6'd4, 6'd0,  5'd0);
    add_op("bltu_neg_pos", K_BLTU,  100,   32'h0248, 6'd3,  6'd4, 6'd0,  5'd0);
    add_op("bgeu_neg_pos", K_BGEU,  2046,  32'h0800, 6'd3,  6'd4, 6'd0,  5'd0);
    add_op("blt_min_max",  K_BLT,   2048,  32'h1000, 6'd5,  6'd6, 6'd0,  5'd0);
    add_op("bltu_max_min", K_BLTU, -4096,  32'h4000, 6'd6,  6'd5, 6'd0,  5'd0);
    add_op("jal_link",     K_JAL,   2048,  32'h0100, 6'd0,  6'd0, 6'd40, 5'd1);
    add_op("beq_link",     K_BEQ,   16,    32'h0108, 6'd40, 6'd8, 6'd0,  5'd0);
    add_op("jalr_rvc",     K_JALR,  7,     32'h0300, 6'd7,  6'd0, 6'd41, 5'd5);
    ops[n_ops-1].rvc = 1'b1;
    add_op("jal_x0",       K_JAL,  -256,   32'h0500, 6'd0,  6'd0, 6'd42, 5'd0);
    add_op("fwd_ex2",      K_BEQ,   32,    32'h0600, 6'd1,  6'd9, 6'd0,  5'd0);
    set_spec(1'b0, 1'b1, 2'd2, 6'd9, 32'd5);
    add_op("fwd_ex1",      K_BNE,   32,    32'h0640, 6'd10, 6'd2, 6'd0,  5'd0);
    set_spec(1'b0, 1'b0, 2'd1, 6'd10, 32'd5);
    add_op("pred_miss",    K_BEQ,   32,    32'h0680, 6'd1,  6'd11, 6'd0, 5'd0);
    set_spec(1'b0, 1'b1, 2'd0, 6'd0, 32'd0);
    add_op("kill_older",   K_BEQ,   64,    32'h0700, 6'd1,  6'd2, 6'd0,  5'd0);
    set_group(2'd1, 4'b0000, 1'b1, 1'b0, 1'b0);
    add_op("kill_younger", K_JAL,   128,   32'h0704, 6'd0,  6'd0, 6'd43, 5'd3);
    set_group(2'd0, 4'b0010, 1'b1, 1'b0, 1'b1);
    add_op("kill_other",   K_BNE,   8,     32'h0708, 6'd3,  6'd4, 6'd0,  5'd0);
    set_group(2'd2, 4'b0100, 1'b0, 1'b0, 1'b0);
    add_op("flush_a",      K_BEQ,   64,    32'h0800, 6'd1,  6'd2, 6'd0,  5'd0);
    set_group(2'd0, 4'b0000, 1'b1, 1'b0, 1'b1);
    add_op("flush_b",      K_BGE,   64,    32'h0804, 6'd5,  6'd6, 6'd0,  5'd0);
    set_group(2'd0, 4'b0000, 1'b1, 1'b0, 1'b1);
    add_op("flush_c",      K_JALR,  0,     32'h0808, 6'd7,  6'd0, 6'd44, 5'd6);
    set_group(2'd0, 4'b0000, 1'b0, 1'b1, 1'b1);
    add_op("after_flush",  K_BLTU,  12,    32'h080c, 6'd1,  6'd4, 6'd0,  5'd0);
  endtask

  // fills the register file over the forwarding bus
  task automatic preload_regs();
    int r;
    r = 1;
    while (r < `BRU_PREG_NUM) begin
      @(posedge i_clk);
      #1;
      for (int p = 0; p < `BRU_FWD_NUM; p++) begin
        i_fwd_bus[p] = '0;
        if (r < `BRU_PREG_NUM) begin
          if (r <= 8) begin
            model_regs[r] = edge_val(r);
          end else begin
            model_regs[r] = rand_word();
          end
          i_fwd_bus[p] = '{valid: 1'b1, rd_rnid: 6'(r), rd_data: model_regs[r]};
          r++;
        end
      end
    end
    @(posedge i_clk);
    #1;
    for (int p = 0; p < `BRU_FWD_NUM; p++) begin
      i_fwd_bus[p] = '0;
    end
  endtask

  task automatic drive_issue(input int i);
    issue_t iss;
    logic   jump;
    jump = (ops[i].kind == K_JAL) || (ops[i].kind == K_JALR);
    iss = '0;
    iss.valid = 1'b1;
    iss.inst = encode(ops[i].kind, ops[i].rd_idx, ops[i].imm);
    iss.pc_addr = ops[i].pc;
    iss.is_rvc = ops[i].rvc;
    iss.cmt_id = 6'(i);
    iss.brtag = ops[i].brtag;
    iss.br_mask = ops[i].mask;
    iss.rs1_valid = (ops[i].kind != K_JAL);
    iss.rs1_rnid = ops[i].rs1;
    iss.rs1_pred_ready = ops[i].pr1;
    iss.rs2_valid = !jump;
    iss.rs2_rnid = ops[i].rs2;
    iss.rs2_pred_ready = ops[i].pr2;
    iss.rd_valid = jump;
    iss.rd_rnid = ops[i].rd_rnid;
    iss.rd_regidx = ops[i].rd_idx;
    i_issue = iss;
    i_commit_flush = ops[i].flush;
    issue_cyc[i] = cyc;
    if (ops[i].fwd_cyc != 2'd0) begin
      model_regs[ops[i].fwd_rnid] = ops[i].fwd_data;  // bus also writes the file
    end
    exps[i] = predict(ops[i]);
    if (exps[i].wr) begin
      model_regs[ops[i].rd_rnid] = exps[i].link;
    end
  endtask

  task automatic issue_group(input int first, input int last);
    int stop;
    stop = last - first + 1;
    for (int i = first; i <= last; i++) begin
      if (ops[i].fwd_cyc != 2'd0 && (i - first) + ops[i].fwd_cyc + 1 > stop) begin
        stop = (i - first) + ops[i].fwd_cyc + 1;
      end
    end
    for (int k = 0; k <= stop; k++) begin
      @(posedge i_clk);
      #1;
      i_issue = '0;
      i_commit_flush = 1'b0;
      i_fwd_bus[0] = '0;
      for (int i = first; i <= last; i++) begin
        if (k == i - first) begin
          drive_issue(i);
        end
        if (ops[i].fwd_cyc != 2'd0 && k == (i - first) + ops[i].fwd_cyc) begin
          i_fwd_bus[0] = '{valid: 1'b1, rd_rnid: ops[i].fwd_rnid, rd_data: ops[i].fwd_data};
        end
      end
    end
  endtask

  task automatic report_value(input int i, input string what, input logic [31:0] got,
                              input logic [31:0] exp);
    $display("[ERROR] %0t: test %0d %s %s is %h, expected %h",
             $time, i, names[i], what, got, exp);
    err_cnt++;
  endtask

  task automatic check_op(input int i);
    int errs_before;
    int wait_cnt;
    bit seen;
    errs_before = err_cnt;
    seen = 1'b0;
    wait_cnt = 0;
    if (exps[i].upd) begin
      while (!seen && wait_cnt < 10) begin
        @(negedge i_clk);
        wait_cnt++;
        if (o_br_upd.update && o_br_upd.cmt_id == 6'(i)) begin
          seen = 1'b1;
        end else if (o_done.done || o_phy_wr.valid) begin
          report_value(i, "done/write without update", {o_done.done, o_phy_wr.valid}, 0);
        end
      end
      if (!seen) begin
        $display("test %0d %s timed out waiting for the branch update", i, names[i]);
        err_cnt++;
      end else begin
        if (cyc != issue_cyc[i] + 3) begin
          report_value(i, "latency", cyc - issue_cyc[i], 3);
        end
        if (o_br_upd.dead != exps[i].dead) begin
          report_value(i, "dead", o_br_upd.dead, exps[i].dead);
        end
        if (o_br_upd.pc_vaddr != ops[i].pc) begin
          report_value(i, "pc", o_br_upd.pc_vaddr, ops[i].pc);
        end
        if (o_br_upd.brtag != ops[i].brtag) begin
          report_value(i, "brtag", o_br_upd.brtag, ops[i].brtag);
        end
        if (o_br_upd.br_mask != ops[i].mask) begin
          report_value(i, "br_mask", o_br_upd.br_mask, ops[i].mask);
        end
        if (!exps[i].dead && o_br_upd.mispredict != exps[i].taken) begin
          report_value(i, "mispredict", o_br_upd.mispredict, exps[i].taken);
        end
        if (!exps[i].dead && o_br_upd.target_vaddr != exps[i].target) begin
          report_value(i, "target", o_br_upd.target_vaddr, exps[i].target);
        end
        if (o_done.done != !exps[i].dead) begin
          report_value(i, "done", o_done.done, !exps[i].dead);
        end
        if (o_done.done && o_done.cmt_id != 6'(i)) begin
          report_value(i, "done cmt_id", o_done.cmt_id, i);
        end
        if (o_phy_wr.valid != exps[i].wr) begin
          report_value(i, "link write valid", o_phy_wr.valid, exps[i].wr);
        end
        if (exps[i].wr && o_phy_wr.rd_rnid != ops[i].rd_rnid) begin
          report_value(i, "link rnid", o_phy_wr.rd_rnid, ops[i].rd_rnid);
        end
        if (exps[i].wr && o_phy_wr.rd_data != exps[i].link) begin
          report_value(i, "link data", o_phy_wr.rd_data, exps[i].link);
        end
      end
    end else begin
      // a replayed op leaves no trace
      for (wait_cnt = 0; wait_cnt < 6; wait_cnt++) begin
        @(negedge i_clk);
        if (o_br_upd.update || o_done.done || o_phy_wr.valid) begin
          report_value(i, "update/done/write of replayed op",
                       {o_br_upd.update, o_done.done, o_phy_wr.valid}, 0);
        end
      end
    end
    if (err_cnt == errs_before) begin
      $display("test %0d %s passed", i, names[i]);
    end else begin
      $display("test %0d %s failed", i, names[i]);
      fail_cnt++;
    end
  endtask

  initial begin
    int first;
    int last;
    i_reset_n = 1'b0;
    i_issue = '0;
    i_commit_flush = 1'b0;
    for (int p = 0; p < `BRU_FWD_NUM; p++) begin
      i_fwd_bus[p] = '0;
    end
    for (int r = 0; r < `BRU_PREG_NUM; r++) begin
      model_regs[r] = '0;
    end
    lfsr = 16'd15508;
    err_cnt = 0;
    fail_cnt = 0;
    n_ops = 0;
    build_table();
    repeat (5) @(posedge i_clk);
    #1;
    i_reset_n = 1'b1;
    preload_regs();
    first = 0;
    while (first < n_ops) begin
      last = first;
      while (ops[last].chain && last + 1 < n_ops) begin
        last++;
      end
      issue_group(first, last);
      for (int i = first; i <= last; i++) begin
        check_op(i);
      end
      first = last + 1;
    end
    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             n_ops, n_ops - fail_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+design
design/bru_pkg.sv
design/bru_decode_stage.sv
design/bru_regfile.sv
design/bru_operand_stage.sv
design/bru_exec_stage.sv
design/bru_pipe_top.sv
dv/bru_tb.sv
